//--- rtl/simd_alu_params.svh
/*
 * Packed-SIMD ALU sizing
 * Word, byte-lane and lane-count definitions shared by the package and the RTL
 */

`ifndef SIMD_ALU_PARAMS_SVH
`define SIMD_ALU_PARAMS_SVH

// Data word width
`define SIMD_XLEN 32

// Width of one byte lane, the smallest SIMD element
`define SIMD_LANE_BITS 8

// Byte lanes per word
`define SIMD_LANES 4

`endif

//--- rtl/simd_alu_pkg.sv
/*
 * Packed-SIMD ALU types
 * Opcodes, lane widths, request/response and decoded control structures
 */

`include "simd_alu_params.svh"

package simd_alu_pkg;

  typedef enum logic [4:0] {
    OP_ADD, OP_SUB,
    OP_KADD, OP_KSUB, OP_UKADD, OP_UKSUB,
    OP_RADD, OP_RSUB, OP_URADD, OP_URSUB,
    OP_CMPEQ, OP_SCMPLT, OP_UCMPLT,
    OP_SMIN, OP_SMAX, OP_UMIN, OP_UMAX
  } simd_op_e;

  typedef enum logic [1:0] {
    W8, W16, W32
  } lane_width_e;

  typedef enum logic [1:0] {
    RES_SUM, RES_CMP, RES_MINMAX
  } result_sel_e;

  typedef struct packed {
    simd_op_e                 op;
    lane_width_e              width;
    logic [`SIMD_XLEN-1:0]    operand_a;
    logic [`SIMD_XLEN-1:0]    operand_b;
  } simd_req_t;

  // Datapath steering, one bit per function
  typedef struct packed {
    logic        sub;
    logic        signed_ops;
    logic        saturate;
    logic        halve;
    result_sel_e result_sel;
    logic        cmp_less;
    logic        pick_max;
  } simd_ctrl_t;

  typedef struct packed {
    logic [`SIMD_XLEN-1:0] result;
    logic                  ov;
  } simd_rsp_t;

  // Per byte: 8 sum bits plus carry out, or the lane extension bit on a lane top
  typedef logic [`SIMD_LANES-1:0][`SIMD_LANE_BITS:0] lane_sum_t;

endpackage

//--- rtl/simd_op_decode.sv
/*
 * SIMD opcode decoder
 * Maps each opcode onto the datapath controls
 */

`timescale 1ns/1ps

module simd_op_decode import simd_alu_pkg::*; (
  input  simd_op_e   op_i,
  output simd_ctrl_t ctrl_o
);

  ////////////////////////////////////////////////////////////
  // Arithmetic controls
  ////////////////////////////////////////////////////////////

  // Comparisons and min/max all work on the difference a - b
  assign ctrl_o.sub = op_i inside {
    OP_SUB, OP_KSUB, OP_UKSUB, OP_RSUB, OP_URSUB,
    OP_CMPEQ, OP_SCMPLT, OP_UCMPLT,
    OP_SMIN, OP_SMAX, OP_UMIN, OP_UMAX
  };

  assign ctrl_o.signed_ops = op_i inside {
    OP_KADD, OP_KSUB, OP_RADD, OP_RSUB,
    OP_SCMPLT, OP_SMIN, OP_SMAX
  };

  assign ctrl_o.saturate = op_i inside {OP_KADD, OP_KSUB, OP_UKADD, OP_UKSUB};

  assign ctrl_o.halve = op_i inside {OP_RADD, OP_RSUB, OP_URADD, OP_URSUB};

  ////////////////////////////////////////////////////////////
  // Compare and result class
  ////////////////////////////////////////////////////////////

  // Less-than mask instead of equality mask
  assign ctrl_o.cmp_less = op_i inside {OP_SCMPLT, OP_UCMPLT};

  assign ctrl_o.pick_max = op_i inside {OP_SMAX, OP_UMAX};

  always_comb begin
    case (op_i)
      OP_CMPEQ, OP_SCMPLT, OP_UCMPLT: begin
        ctrl_o.result_sel = RES_CMP;
      end
      OP_SMIN, OP_SMAX, OP_UMIN, OP_UMAX: begin
        ctrl_o.result_sel = RES_MINMAX;
      end
      default: begin
        ctrl_o.result_sel = RES_SUM;
      end
    endcase
  end

endmodule

//--- rtl/simd_lane_adder.sv
/*
 * Lane-split adder
 * Four byte adders whose carries are chained or cut by lane width
 */

`timescale 1ns/1ps

`include "simd_alu_params.svh"

module simd_lane_adder import simd_alu_pkg::*; (
  input  logic [`SIMD_XLEN-1:0] operand_a_i,
  input  logic [`SIMD_XLEN-1:0] operand_b_i,
  input  lane_width_e           width_i,
  input  simd_ctrl_t            ctrl_i,
  output lane_sum_t             sums_o,
  output logic [`SIMD_XLEN-1:0] sum_o
);

  ////////////////////////////////////////////////////////////
  // Lane boundaries
  ////////////////////////////////////////////////////////////

  // Bytes that open a lane take the subtract carry-in,
  // bytes that close a lane get the sign/zero extension bit
  logic [`SIMD_LANES-1:0] lane_start;
  logic [`SIMD_LANES-1:0] lane_top;

  always_comb begin
    case (width_i)
      W8: begin
        lane_start = 4'b1111;
        lane_top   = 4'b1111;
      end
      W16: begin
        lane_start = 4'b0101;
        lane_top   = 4'b1010;
      end
      default: begin
        lane_start = 4'b0001;
        lane_top   = 4'b1000;
      end
    endcase
  end

  ////////////////////////////////////////////////////////////
  // Byte adders
  ////////////////////////////////////////////////////////////

  for (genvar b = 0; b < `SIMD_LANES; b++) begin : gen_byte
    logic [`SIMD_LANE_BITS-1:0] a_in;
    logic [`SIMD_LANE_BITS-1:0] b_in;
    logic                       ext_a;
    logic                       ext_b;
    logic                       carry_prev;
    logic                       carry_in;
    logic [`SIMD_LANE_BITS:0]   byte_sum;

    assign a_in = operand_a_i[b*`SIMD_LANE_BITS +: `SIMD_LANE_BITS];
    assign b_in = operand_b_i[b*`SIMD_LANE_BITS +: `SIMD_LANE_BITS] ^
                  {`SIMD_LANE_BITS{ctrl_i.sub}};

    // Extension bit on lane tops, inverted along with B for subtraction
    assign ext_a = lane_top[b] & ctrl_i.signed_ops & a_in[`SIMD_LANE_BITS-1];
    assign ext_b = lane_top[b] &
                   ((ctrl_i.signed_ops & operand_b_i[(b+1)*`SIMD_LANE_BITS-1]) ^ ctrl_i.sub);

    if (b == 0) begin : gen_first
      assign carry_prev = 1'b0;
    end else begin : gen_chain
      assign carry_prev = gen_byte[b-1].byte_sum[`SIMD_LANE_BITS];
    end

    assign carry_in = lane_start[b] ? ctrl_i.sub : carry_prev;

    assign byte_sum = {ext_a, a_in} + {ext_b, b_in} + {{`SIMD_LANE_BITS{1'b0}}, carry_in};

    assign sums_o[b] = byte_sum;
    assign sum_o[b*`SIMD_LANE_BITS +: `SIMD_LANE_BITS] = byte_sum[`SIMD_LANE_BITS-1:0];
  end

endmodule

//--- rtl/simd_saturate.sv
/*
 * SIMD saturation and halving
 * Clamps lanes that left their range, or halves the extended lane sums
 */

`timescale 1ns/1ps

`include "simd_alu_params.svh"

module simd_saturate import simd_alu_pkg::*; (
  input  lane_sum_t             sums_i,
  input  lane_width_e           width_i,
  input  simd_ctrl_t            ctrl_i,
  output logic [`SIMD_XLEN-1:0] result_o,
  output logic                  ov_o
);

  logic [`SIMD_LANES-1:0][1:0]                    top_idx;
  logic [`SIMD_LANES-1:0][`SIMD_LANE_BITS:0]      top_sum;
  logic [`SIMD_LANES-1:0]                         is_top;
  logic [`SIMD_LANES-1:0]                         lane_ovf;
  logic [`SIMD_LANES-1:0]                         lsb_vec;
  logic [`SIMD_LANES-1:0]                         above_lsb;
  logic [`SIMD_LANES-1:0][`SIMD_LANE_BITS-1:0]    limit;
  logic [`SIMD_XLEN-1:0]                          wrapped;
  logic [`SIMD_XLEN-1:0]                          clamped;
  logic [`SIMD_XLEN-1:0]                          halved;

  ////////////////////////////////////////////////////////////
  // Range check per lane
  ////////////////////////////////////////////////////////////

  always_comb begin
    for (int b = 0; b < `SIMD_LANES; b++) begin
      // Byte holding the top of this byte's lane
      case (width_i)
        W8:      top_idx[b] = 2'(b);
        W16:     top_idx[b] = 2'(b | 1);
        default: top_idx[b] = 2'(`SIMD_LANES - 1);
      endcase
      top_sum[b] = sums_i[top_idx[b]];
      is_top[b]  = (top_idx[b] == 2'(b));

      // Signed: bits 8 and 7 disagree; unsigned: bit 8 is carry or borrow
      lane_ovf[b] = ctrl_i.signed_ops ?
                    (top_sum[b][`SIMD_LANE_BITS] ^ top_sum[b][`SIMD_LANE_BITS-1]) :
                    top_sum[b][`SIMD_LANE_BITS];

      // Signed limit follows the error side, unsigned clamps to 0 or all ones
      if (ctrl_i.signed_ops) begin
        if (is_top[b]) begin
          limit[b] = {top_sum[b][`SIMD_LANE_BITS],
                      {(`SIMD_LANE_BITS-1){~top_sum[b][`SIMD_LANE_BITS]}}};
        end else begin
          limit[b] = {`SIMD_LANE_BITS{~top_sum[b][`SIMD_LANE_BITS]}};
        end
      end else begin
        limit[b] = {`SIMD_LANE_BITS{~ctrl_i.sub}};
      end

      wrapped[b*`SIMD_LANE_BITS +: `SIMD_LANE_BITS] = sums_i[b][`SIMD_LANE_BITS-1:0];
      clamped[b*`SIMD_LANE_BITS +: `SIMD_LANE_BITS] =
        lane_ovf[b] ? limit[b] : sums_i[b][`SIMD_LANE_BITS-1:0];
      lsb_vec[b] = sums_i[b][0];
    end
  end

  ////////////////////////////////////////////////////////////
  // Halving
  ////////////////////////////////////////////////////////////

  // Bit shifted into a byte's MSB comes from the next byte up inside a lane
  assign above_lsb = lsb_vec >> 1;

  always_comb begin
    for (int b = 0; b < `SIMD_LANES; b++) begin
      halved[b*`SIMD_LANE_BITS +: `SIMD_LANE_BITS] = {
        is_top[b] ? sums_i[b][`SIMD_LANE_BITS] : above_lsb[b],
        sums_i[b][`SIMD_LANE_BITS-1:1]
      };
    end
  end

  assign result_o = ctrl_i.saturate ? clamped : (ctrl_i.halve ? halved : wrapped);
  assign ov_o     = ctrl_i.saturate & (|lane_ovf);

endmodule

//--- rtl/simd_compare.sv
/*
 * SIMD lane comparison
 * Equality and less-than masks, and per-lane min/max selection
 */

`timescale 1ns/1ps

`include "simd_alu_params.svh"

module simd_compare import simd_alu_pkg::*; (
  input  logic [`SIMD_XLEN-1:0] operand_a_i,
  input  logic [`SIMD_XLEN-1:0] operand_b_i,
  input  lane_sum_t             sums_i,
  input  lane_width_e           width_i,
  input  simd_ctrl_t            ctrl_i,
  output logic [`SIMD_XLEN-1:0] cmp_o,
  output logic [`SIMD_XLEN-1:0] minmax_o
);

  logic [`SIMD_LANES-1:0] byte_eq;
  logic [`SIMD_LANES-1:0] byte_lt;
  logic [`SIMD_LANES-1:0] lane_eq;
  logic [`SIMD_LANES-1:0] lane_lt;
  logic [`SIMD_LANES-1:0] lane_flag;
  logic [`SIMD_LANES-1:0] a_sign;
  logic [`SIMD_LANES-1:0] b_sign;

  // Per-byte flags from the difference a - b
  always_comb begin
    for (int b = 0; b < `SIMD_LANES; b++) begin
      a_sign[b]  = operand_a_i[(b+1)*`SIMD_LANE_BITS-1];
      b_sign[b]  = operand_b_i[(b+1)*`SIMD_LANE_BITS-1];
      byte_eq[b] = (sums_i[b][`SIMD_LANE_BITS-1:0] == '0);
      // Same signs: difference sign decides; else the operand signs do
      if (a_sign[b] == b_sign[b]) begin
        byte_lt[b] = sums_i[b][`SIMD_LANE_BITS-1];
      end else begin
        byte_lt[b] = ctrl_i.signed_ops ? a_sign[b] : b_sign[b];
      end
    end
  end

  // Merge bytes into lanes, less-than is taken at the lane top
  always_comb begin
    case (width_i)
      W8: begin
        lane_eq = byte_eq;
        lane_lt = byte_lt;
      end
      W16: begin
        lane_eq = {{2{&byte_eq[3:2]}}, {2{&byte_eq[1:0]}}};
        lane_lt = {{2{byte_lt[3]}}, {2{byte_lt[1]}}};
      end
      default: begin
        lane_eq = {`SIMD_LANES{&byte_eq}};
        lane_lt = {`SIMD_LANES{byte_lt[3]}};
      end
    endcase
  end

  assign lane_flag = ctrl_i.cmp_less ? lane_lt : lane_eq;

  always_comb begin
    for (int b = 0; b < `SIMD_LANES; b++) begin
      cmp_o[b*`SIMD_LANE_BITS +: `SIMD_LANE_BITS] = {`SIMD_LANE_BITS{lane_flag[b]}};
      // Min keeps A when a < b, max keeps B
      minmax_o[b*`SIMD_LANE_BITS +: `SIMD_LANE_BITS] = (lane_lt[b] ^ ctrl_i.pick_max) ?
        operand_a_i[b*`SIMD_LANE_BITS +: `SIMD_LANE_BITS] :
        operand_b_i[b*`SIMD_LANE_BITS +: `SIMD_LANE_BITS];
    end
  end

endmodule

//--- rtl/simd_alu_top.sv
/*
 * Packed-SIMD arithmetic unit
 * Request register, datapath and result register in a two-stage pipeline
 */

`timescale 1ns/1ps

`include "simd_alu_params.svh"

module simd_alu_top import simd_alu_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_n_i,
  input  logic      in_valid_i,
  input  simd_req_t req_i,
  output logic      out_valid_o,
  output simd_rsp_t rsp_o
);

  logic                  req_valid_q;
  simd_req_t             req_q;
  simd_ctrl_t            ctrl;
  lane_sum_t             sums;
  logic [`SIMD_XLEN-1:0] sum_wrapped;
  logic [`SIMD_XLEN-1:0] sat_result;
  logic                  sat_ov;
  logic [`SIMD_XLEN-1:0] cmp_result;
  logic [`SIMD_XLEN-1:0] minmax_result;
  simd_rsp_t             rsp_d;

  ////////////////////////////////////////////////////////////
  // Stage 1 request register
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      req_valid_q <= 1'b0;
    end else begin
      req_valid_q <= in_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (in_valid_i) begin
      req_q <= req_i;
    end
  end

  ////////////////////////////////////////////////////////////
  // Datapath
  ////////////////////////////////////////////////////////////

  simd_op_decode u_decode (
    .op_i   (req_q.op),
    .ctrl_o (ctrl)
  );

  simd_lane_adder u_adder (
    .operand_a_i (req_q.operand_a),
    .operand_b_i (req_q.operand_b),
    .width_i     (req_q.width),
    .ctrl_i      (ctrl),
    .sums_o      (sums),
    .sum_o       (sum_wrapped)
  );

  simd_saturate u_saturate (
    .sums_i   (sums),
    .width_i  (req_q.width),
    .ctrl_i   (ctrl),
    .result_o (sat_result),
    .ov_o     (sat_ov)
  );

  simd_compare u_compare (
    .operand_a_i (req_q.operand_a),
    .operand_b_i (req_q.operand_b),
    .sums_i      (sums),
    .width_i     (req_q.width),
    .ctrl_i      (ctrl),
    .cmp_o       (cmp_result),
    .minmax_o    (minmax_result)
  );

  // Select the result class, ov only kept for saturating sums
  always_comb begin
    rsp_d = '0;
    case (ctrl.result_sel)
      RES_CMP:    rsp_d.result = cmp_result;
      RES_MINMAX: rsp_d.result = minmax_result;
      default: begin
        rsp_d.result = (ctrl.saturate | ctrl.halve) ? sat_result : sum_wrapped;
        rsp_d.ov     = ctrl.saturate & sat_ov;
      end
    endcase
  end

  ////////////////////////////////////////////////////////////
  // Stage 2 result register
  ////////////////////////////////////////////////////////////

  // Response reads zero between results
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      out_valid_o <= 1'b0;
      rsp_o       <= '0;
    end else begin
      out_valid_o <= req_valid_q;
      if (req_valid_q) begin
        rsp_o <= rsp_d;
      end else begin
        rsp_o <= '0;
      end
    end
  end

endmodule

//--- verif/simd_alu_props.sv
/*
 * SIMD ALU handshake assertions
 * Strobe-to-valid timing and overflow flag qualification
 */

`timescale 1ns/1ps

module simd_alu_props import simd_alu_pkg::*; (
  input logic      clk_i,
  input logic      rst_n_i,
  input logic      in_valid_i,
  input logic      out_valid_i,
  input simd_rsp_t rsp_i
);

  // Output strobe held low in reset
  a_no_valid_in_reset: assert property (@(posedge clk_i) !rst_n_i |-> !out_valid_i)
    else $error("out_valid_o high while reset is held");

  // Fixed two-stage latency
  a_latency_two: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $past(in_valid_i, 2) |-> out_valid_i)
    else $error("out_valid_o missing two cycles after in_valid_i");

  // Overflow flag only set together with a valid result
  a_ov_with_valid: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    rsp_i.ov |-> out_valid_i)
    else $error("rsp_o.ov high without out_valid_o");

endmodule

//--- verif/simd_alu_tb.sv
/*
 * Packed-SIMD arithmetic unit testbench
 * Table-driven requests, lane-wise reference model and result checks
 */

`timescale 1ns/1ps

`include "simd_alu_params.svh"

module simd_alu_tb import simd_alu_pkg::*; ();

  localparam int CLK_PERIOD   = 100;
  localparam int RESET_CYCLES = 5;
  localparam int TIMEOUT      = 10;
  localparam int NUM_RANDOM   = 40;

  typedef struct packed {
    simd_op_e              op;
    lane_width_e           width;
    logic [`SIMD_XLEN-1:0] a;
    logic [`SIMD_XLEN-1:0] b;
    logic [1:0]            gap;
    simd_rsp_t             exp;
  } stim_t;

  logic      clk;
  logic      rst_n;
  logic      in_valid;
  simd_req_t req;
  logic      out_valid;
  simd_rsp_t rsp;
  logic[1:0] strobe_hist;
  stim_t     stim_table[$];
  simd_rsp_t exp_q[$];
  int        value_errors;
  int        valid_errors;
  int        timeouts;

  simd_alu_top DUT (
    .clk_i       (clk),
    .rst_n_i     (rst_n),
    .in_valid_i  (in_valid),
    .req_i       (req),
    .out_valid_o (out_valid),
    .rsp_o       (rsp)
  );

  bind simd_alu_top simd_alu_props u_props (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .in_valid_i  (in_valid_i),
    .out_valid_i (out_valid_o),
    .rsp_i       (rsp_o)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  ////////////////////////////////////////////////////////////
  // Reference model, one lane at a time
  ////////////////////////////////////////////////////////////

  function automatic simd_rsp_t model_rsp(simd_op_e op, lane_width_e width,
                                          logic [`SIMD_XLEN-1:0] a, logic [`SIMD_XLEN-1:0] b);
    simd_rsp_t rsp_m;
    int        w;
    longint    full;
    longint    mask;
    longint    ua;
    longint    ub;
    longint    sa;
    longint    sb;
    longint    r;
    longint    lo;
    longint    hi;
    rsp_m = '0;
    w = (width == W8) ? 8 : ((width == W16) ? 16 : 32);
    full = longint'(1) << w;
    mask = full - longint'(1);
    for (int i = 0; i < `SIMD_XLEN / w; i++) begin
      ua = longint'(a >> (i * w)) & mask;
      ub = longint'(b >> (i * w)) & mask;
      sa = (ua >= (full >> 1)) ? ua - full : ua;
      sb = (ub >= (full >> 1)) ? ub - full : ub;
      // Signed range for K ops, unsigned otherwise
      lo = (op inside {OP_KADD, OP_KSUB}) ? -(full >> 1) : longint'(0);
      hi = (op inside {OP_KADD, OP_KSUB}) ? (full >> 1) - longint'(1) : mask;
      case (op)
        OP_ADD, OP_UKADD: r = ua + ub;
        OP_SUB, OP_UKSUB: r = ua - ub;
        OP_KADD:          r = sa + sb;
        OP_KSUB:          r = sa - sb;
        OP_RADD:          r = (sa + sb) >>> 1;
        OP_RSUB:          r = (sa - sb) >>> 1;
        OP_URADD:         r = (ua + ub) >>> 1;
        OP_URSUB:         r = (ua - ub) >>> 1;
        OP_CMPEQ:         r = (ua == ub) ? mask : longint'(0);
        OP_SCMPLT:        r = (sa < sb) ? mask : longint'(0);
        OP_UCMPLT:        r = (ua < ub) ? mask : longint'(0);
        OP_SMIN:          r = (sa < sb) ? ua : ub;
        OP_SMAX:          r = (sa < sb) ? ub : ua;
        OP_UMIN:          r = (ua < ub) ? ua : ub;
        default:          r = (ua < ub) ? ub : ua;
      endcase
      if ((op inside {OP_KADD, OP_KSUB, OP_UKADD, OP_UKSUB}) && (r < lo || r > hi)) begin
        r = (r < lo) ? lo : hi;
        rsp_m.ov = 1'b1;
      end
      rsp_m.result = rsp_m.result | `SIMD_XLEN'((r & mask) << (i * w));
    end
    return rsp_m;
  endfunction

  task automatic add_stim(simd_op_e op, lane_width_e width, logic [`SIMD_XLEN-1:0] a,
                          logic [`SIMD_XLEN-1:0] b, logic [1:0] gap);
    stim_t s;
    s.op    = op;
    s.width = width;
    s.a     = a;
    s.b     = b;
    s.gap   = gap;
    s.exp   = model_rsp(op, width, a, b);
    stim_table.push_back(s);
  endtask

  task automatic build_table();
    // Lane boundaries, clamps and sign corners first
    add_stim(OP_ADD,    W8,  32'h7F80FF01, 32'h01800101, 2'd0);
    add_stim(OP_ADD,    W16, 32'hFFFF8000, 32'h00018000, 2'd0);
    add_stim(OP_SUB,    W32, 32'h00000000, 32'h00000001, 2'd1);
    add_stim(OP_SUB,    W8,  32'h00010203, 32'h01010101, 2'd0);
    add_stim(OP_KADD,   W8,  32'h7F80107F, 32'h01FF1001, 2'd0);
    add_stim(OP_KSUB,   W16, 32'h80007FFF, 32'h0001FFFF, 2'd0);
    add_stim(OP_KADD,   W32, 32'h12345678, 32'h11111111, 2'd0);
    add_stim(OP_UKADD,  W32, 32'hFFFFFFF0, 32'h00000020, 2'd0);
    add_stim(OP_UKSUB,  W8,  32'h10FF0005, 32'h20010006, 2'd2);
    add_stim(OP_RADD,   W8,  32'h7F7F8080, 32'h7F018080, 2'd0);
    add_stim(OP_RSUB,   W16, 32'h80007FFF, 32'h7FFF8000, 2'd0);
    add_stim(OP_URADD,  W32, 32'hFFFFFFFF, 32'hFFFFFFFF, 2'd0);
    add_stim(OP_URSUB,  W8,  32'h00FF0102, 32'hFF000201, 2'd0);
    add_stim(OP_CMPEQ,  W16, 32'h12341234, 32'h12341235, 2'd0);
    add_stim(OP_SCMPLT, W8,  32'h80FF017F, 32'h7F00FF80, 2'd0);
    add_stim(OP_UCMPLT, W32, 32'h80000000, 32'h7FFFFFFF, 2'd0);
    add_stim(OP_SMIN,   W16, 32'h8000FFFF, 32'h7FFF0001, 2'd0);
    add_stim(OP_SMAX,   W8,  32'h80FF017F, 32'h7F00FF80, 2'd0);
    add_stim(OP_UMIN,   W32, 32'h80000000, 32'h7FFFFFFF, 2'd0);
    add_stim(OP_UMAX,   W16, 32'h8000FFFF, 32'h7FFF0001, 2'd1);
    for (int i = 0; i < NUM_RANDOM; i++) begin
      add_stim(simd_op_e'(5'($urandom_range(0, 16))),
               lane_width_e'(2'($urandom_range(0, 2))),
               $urandom, $urandom,
               ($urandom_range(0, 3) == 0) ? 2'd1 : 2'd0);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////

  task automatic check_result(simd_rsp_t got, simd_rsp_t exp, string what);
    if (got !== exp) begin
      value_errors++;
      $display("CHECK FAILED @ %0t: %s gave %h ov %b, expected %h ov %b",
               $time, what, got.result, got.ov, exp.result, exp.ov);
    end
  endtask

  task automatic check_valid(logic got, logic exp);
    if (got !== exp) begin
      valid_errors++;
      $display("CHECK FAILED @ %0t: out_valid_o is %b, expected %b", $time, got, exp);
    end
  endtask

  // Two-cycle image of the input strobe
  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      strobe_hist <= 2'b00;
    end else begin
      strobe_hist <= {strobe_hist[0], in_valid};
    end
  end

  initial begin
    forever begin
      @(negedge clk);
      check_valid(out_valid, strobe_hist[1]);
    end
  end

  task automatic drive_requests();
    foreach (stim_table[i]) begin
      @(negedge clk);
      in_valid  = 1'b1;
      req.op    = stim_table[i].op;
      req.width = stim_table[i].width;
      req.operand_a = stim_table[i].a;
      req.operand_b = stim_table[i].b;
      exp_q.push_back(stim_table[i].exp);
      repeat (stim_table[i].gap) begin
        @(negedge clk);
        in_valid = 1'b0;
      end
    end
    @(negedge clk);
    in_valid = 1'b0;
  endtask

  task automatic collect_result(int idx, output logic timed_out);
    int        waited;
    simd_rsp_t exp;
    waited    = 0;
    timed_out = 1'b0;
    do begin
      @(negedge clk);
      waited++;
    end while (!out_valid && waited < TIMEOUT);
    if (!out_valid) begin
      timed_out = 1'b1;
      $display("No result for request %0d within %0d cycles", idx, TIMEOUT);
    end else if (exp_q.size() == 0) begin
      value_errors++;
      $display("A result came out at %0t with no request outstanding", $time);
    end else begin
      exp = exp_q.pop_front();
      check_result(rsp, exp, $sformatf("request %0d %s/%s", idx,
                   stim_table[idx].op.name(), stim_table[idx].width.name()));
    end
  endtask

  initial begin
    logic timed_out;
    void'($urandom(32'h9b027d2f));
    rst_n        = 1'b1;
    in_valid     = 1'b0;
    req          = '0;
    value_errors = 0;
    valid_errors = 0;
    timeouts     = 0;
    build_table();
    #10 rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    fork
      drive_requests();
      begin
        for (int i = 0; i < stim_table.size(); i++) begin
          collect_result(i, timed_out);
          if (timed_out) begin
            timeouts++;
            break;
          end
        end
      end
    join
    repeat (3) @(negedge clk);
    $display("Errors: value %0d, valid %0d, timeout %0d", value_errors, valid_errors, timeouts);
    if (value_errors == 0 && valid_errors == 0 && timeouts == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

//--- compile.f
+incdir+rtl
rtl/simd_alu_pkg.sv
rtl/simd_op_decode.sv
rtl/simd_lane_adder.sv
rtl/simd_saturate.sv
rtl/simd_compare.sv
rtl/simd_alu_top.sv
verif/simd_alu_props.sv
verif/simd_alu_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the SIMD ALU testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert \
  -f compile.f \
  --top-module simd_alu_tb \
  -o Vsimd_alu_tb

./obj_dir/Vsimd_alu_tb | tee sim.log

if grep -q "Simulation finished: PASS" sim.log; then
  echo "Result: simulation passed"
else
  echo "Result: simulation failed"
  exit 1
fi
